// File: test/matrix_vectors.txt
# C op row col data: command, data in hex; E index row: expected row, columns 3 to 0 in hex
# H n: allow n more row credits; S cycles rows: wait, then count rows; R: release; T: name
T reset_stall
H 2
C 7 0 0 0000
S 20 2
C 0 0 0 0000
C 1 0 1 1234
C 1 1 3 5678
C 1 3 2 9abc
R
E 0 0000000000000000
E 1 0000000000000000
E 2 0000000000000000
E 3 0000000000000000
T init_write
C 7 0 0 0000
E 0 0001000112340001
E 1 5678000100010001
E 2 0001000100010001
E 3 00019abc00010001
T shift_up
C 2 0 0 0000
C 7 0 0 0000
E 0 5678000100010001
E 1 0001000100010001
E 2 00019abc00010001
E 3 0001000112340001
T shift_left
C 4 0 0 0000
C 7 0 0 0000
E 0 0001567800010001
E 1 0001000100010001
E 2 000100019abc0001
E 3 0001000100011234
T shift_down
C 3 0 0 0000
C 7 0 0 0000
E 0 0001000100011234
E 1 0001567800010001
E 2 0001000100010001
E 3 000100019abc0001
T shift_right
C 5 0 0 0000
C 7 0 0 0000
E 0 0001000112340001
E 1 5678000100010001
E 2 0001000100010001
E 3 00019abc00010001
T transpose
C 6 0 0 0000
C 7 0 0 0000
E 0 0001000100010001
E 1 0001000100011234
E 2 9abc000100010001
E 3 0001000156780001
T transpose_back
C 6 0 0 0000
C 7 0 0 0000
E 0 0001000112340001
E 1 5678000100010001
E 2 0001000100010001
E 3 00019abc00010001

// File: all.f
+incdir+rtl
rtl/matrix_pkg.sv
rtl/matrix_array_if.sv
rtl/cmd_queue.sv
rtl/credit_counter.sv
rtl/matrix_ctrl_fsm.sv
rtl/matrix_array.sv
rtl/matrix_reg_unit.sv
test/tb_matrix_reg_unit.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing -f all.f --top-module tb_matrix_reg_unit -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// File: test/tb_matrix_reg_unit.sv
`include "matrix_defines.svh"

module tb_matrix_reg_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import matrix_pkg::*;

  localparam int N       = `MATRIX_N;
  localparam int TIMEOUT = 200;

  logic       clk = 1'b0;
  logic       rstnn;
  logic       i_cmd_valid;
  matrix_op_e i_cmd_op;
  idx_t       i_cmd_row;
  idx_t       i_cmd_col;
  scalar_t    i_cmd_data;
  logic       o_cmd_credit;
  logic       i_row_credit;
  logic       o_row_valid;
  idx_t       o_row_index;
  row_t       o_row_data;

  // Sender, receiver and scoreboard state
  int    cmds_sent;
  int    credit_pulses;
  int    rows_expected;
  int    rows_seen;
  int    granted;
  int    grant_cap;
  int    grant_gap;
  int    rx_next;
  int    checks;
  int    check_errors;
  int    flow_errors;
  bit    timed_out;
  string test_name;
  idx_t  rx_index [$];
  row_t  rx_data [$];

  matrix_reg_unit uut (.*);

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, sampled at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rstnn)
    begin
      if (o_cmd_credit)
        credit_pulses++;
      if (i_cmd_valid && i_cmd_op == OP_READ)
        rows_expected += N;
      if (o_row_valid)
      begin
        rows_seen++;
        if (rows_seen > granted || rows_seen > rows_expected)
        begin
          flow_errors++;
          $display("Row %0d arrived without an unspent row credit", rows_seen);
        end
        rx_index.push_back(o_row_index);
        rx_data.push_back(o_row_data);
      end
    end
  end

  // Receiver grants row credits after random gaps, never above the limit
  initial
  begin
    i_row_credit = 1'b0;
    // Seeding also draws the first gap
    grant_gap = $urandom(32'hfb7f_9292) % 4;
    forever
    begin
      @(negedge clk);
      i_row_credit = 1'b0;
      if (rstnn && grant_gap > 0)
        grant_gap--;
      else if (rstnn && granted < rows_expected && granted < grant_cap
               && granted - rows_seen < `ROW_CREDIT_MAX)
      begin
        i_row_credit = 1'b1;
        granted++;
        grant_gap = $urandom % 4;
      end
    end
  end

  // Ends the run once any wait has run out of time
  initial
  begin
    wait (timed_out);
    $display("Checks: %0d, value errors: %0d, flow errors: %0d",
             checks, check_errors, flow_errors);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_or_abort(input string what, inout int waited);
    @(negedge clk);
    waited++;
    if (waited > TIMEOUT && !timed_out)
    begin
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_cmd(input int op, input int row, input int col, input int data);
    int waited;
    waited = 0;
    while (`CMD_DEPTH + credit_pulses - cmds_sent <= 0)
      step_or_abort("a command credit", waited);
    i_cmd_valid = 1'b1;
    i_cmd_op    = matrix_op_e'(op);
    i_cmd_row   = idx_t'(row);
    i_cmd_col   = idx_t'(col);
    i_cmd_data  = scalar_t'(data);
    cmds_sent++;
    @(negedge clk);
    i_cmd_valid = 1'b0;
  endtask

  task automatic check_row(input int idx, input row_t expected);
    int waited;
    waited = 0;
    while (rx_data.size() <= rx_next)
      step_or_abort("a readout row", waited);
    checks++;
    if (rx_index[rx_next] != idx_t'(idx) || rx_data[rx_next] != expected)
    begin
      check_errors++;
      $display("Fail %s row %0d: expected %0d %h, actual %0d %h", test_name, idx,
               idx, expected, rx_index[rx_next], rx_data[rx_next]);
    end
    rx_next++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int               fd;
    int               code;
    int               waited;
    int               op;
    int               row;
    int               col;
    int               data;
    int               arg_a;
    int               arg_b;
    row_t             expected;
    string            tag;
    logic [8*128-1:0] line;

    rstnn       = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_op    = OP_INIT;
    i_cmd_row   = '0;
    i_cmd_col   = '0;
    i_cmd_data  = '0;
    grant_cap   = 1 << 30;
    test_name   = "reset";
    repeat (10) @(negedge clk);
    rstnn = 1'b1;
    @(negedge clk);
    checks++;
    if (o_cmd_credit || o_row_valid)
    begin
      check_errors++;
      $display("Fail reset strobes: expected 00, actual %b%b", o_cmd_credit, o_row_valid);
    end

    fd = $fopen("test/matrix_vectors.txt", "r");
    if (fd == 0)
    begin
      check_errors++;
      $display("Could not open the vector file test/matrix_vectors.txt");
    end
    else
    begin
      while ($fscanf(fd, "%s", tag) == 1)
      begin
        case (tag)
          "#":
            code = $fgets(line, fd);
          "T":
            code = $fscanf(fd, "%s", test_name);
          "C":
          begin
            code = $fscanf(fd, "%d %d %d %h", op, row, col, data);
            send_cmd(op, row, col, data);
          end
          "E":
          begin
            code = $fscanf(fd, "%d %h", arg_a, expected);
            check_row(arg_a, expected);
          end
          // Credit limits change away from the falling edge the receiver acts on
          "H":
          begin
            code = $fscanf(fd, "%d", arg_a);
            @(posedge clk);
            grant_cap = granted + arg_a;
            @(negedge clk);
          end
          "R":
          begin
            @(posedge clk);
            grant_cap = 1 << 30;
            @(negedge clk);
          end
          "S":
          begin
            code = $fscanf(fd, "%d %d", arg_a, arg_b);
            repeat (arg_a) @(negedge clk);
            checks++;
            if (rx_data.size() - rx_next != arg_b)
            begin
              check_errors++;
              $display("Fail %s stalled rows: expected %0d, actual %0d", test_name,
                       arg_b, rx_data.size() - rx_next);
            end
          end
          default:
          begin
            check_errors++;
            $display("Unknown record %s in the vector file", tag);
          end
        endcase
      end
      $fclose(fd);
    end

    // Every command must hand its credit back, and no extra pulses follow
    waited = 0;
    while (credit_pulses < cmds_sent)
      step_or_abort("the last command credits", waited);
    repeat (5) @(negedge clk);
    checks++;
    if (credit_pulses != cmds_sent)
    begin
      check_errors++;
      $display("Fail command credits: expected %0d, actual %0d", cmds_sent, credit_pulses);
    end
    checks++;
    if (rows_seen != rows_expected || rx_next != rx_data.size())
    begin
      check_errors++;
      $display("Fail row count: expected %0d, actual %0d", rows_expected, rows_seen);
    end

    $display("Checks: %0d, value errors: %0d, flow errors: %0d",
             checks, check_errors, flow_errors);
    if (check_errors == 0 && flow_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: rtl/matrix_reg_unit.sv
module matrix_reg_unit
(
  input  logic                    clk,
  input  logic                    rstnn,

  // Command port
  input  logic                    i_cmd_valid,
  input  matrix_pkg::matrix_op_e  i_cmd_op,
  input  matrix_pkg::idx_t        i_cmd_row,
  input  matrix_pkg::idx_t        i_cmd_col,
  input  matrix_pkg::scalar_t     i_cmd_data,
  output logic                    o_cmd_credit,

  // Row readout port
  input  logic                    i_row_credit,
  output logic                    o_row_valid,
  output matrix_pkg::idx_t        o_row_index,
  output matrix_pkg::row_t        o_row_data
);
  import matrix_pkg::*;

  cmd_t cmd_in;
  cmd_t cmd_head;
  logic queue_empty;
  logic cmd_pop;
  logic row_has_credit;

  assign cmd_in = '{op: i_cmd_op, row: i_cmd_row, col: i_cmd_col, data: i_cmd_data};

  matrix_array_if u_array_if ();

  cmd_queue u_cmd_queue
  (
    .clk      (clk),
    .rstnn    (rstnn),
    .i_push   (i_cmd_valid),
    .i_cmd    (cmd_in),
    .i_pop    (cmd_pop),
    .o_empty  (queue_empty),
    .o_cmd    (cmd_head),
    .o_credit (o_cmd_credit)
  );

  // Each row put on the output spends one receiver credit
  credit_counter u_credit_counter
  (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_grant      (i_row_credit),
    .i_spend      (o_row_valid),
    .o_has_credit (row_has_credit)
  );

  matrix_ctrl_fsm u_ctrl_fsm
  (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_empty      (queue_empty),
    .i_cmd        (cmd_head),
    .o_pop        (cmd_pop),
    .i_has_credit (row_has_credit),
    .o_row_valid  (o_row_valid),
    .o_row_index  (o_row_index),
    .o_row_data   (o_row_data),
    .arr          (u_array_if.ctrl)
  );

  matrix_array u_matrix_array
  (
    .clk   (clk),
    .rstnn (rstnn),
    .arr   (u_array_if.array)
  );

endmodule

// File: rtl/matrix_array.sv
`include "matrix_defines.svh"

module matrix_array
(
  input  logic          clk,
  input  logic          rstnn,
  matrix_array_if.array arr
);
  import matrix_pkg::*;

  localparam int N = `MATRIX_N;

  localparam scalar_t INIT_VALUE = scalar_t'(`MATRIX_INIT_VALUE);

  // Element (0,0) is the upper left corner
  scalar_t data     [N][N];
  scalar_t data_nxt [N][N];

  ////////////////////////////////////////////////////////////////////////////
  // Next matrix value
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    data_nxt = data;
    if (arr.op_valid)
    begin
      case (arr.op)
        OP_INIT:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = INIT_VALUE;
        end
        OP_WRITE:
          data_nxt[arr.row][arr.col] = arr.wdata;
        // Rotations wrap the far edge around to the near one
        OP_SHIFT_UP:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = data[(r + 1) % N][c];
        end
        OP_SHIFT_DOWN:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = data[(r + N - 1) % N][c];
        end
        OP_SHIFT_LEFT:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = data[r][(c + 1) % N];
        end
        OP_SHIFT_RIGHT:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = data[r][(c + N - 1) % N];
        end
        OP_TRANSPOSE:
        begin
          for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
              data_nxt[r][c] = data[c][r];
        end
        default:
          data_nxt = data;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      for (int r = 0; r < N; r++)
        for (int c = 0; c < N; c++)
          data[r][c] <= '0;
    end
    else
    begin
      data <= data_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Row read
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int c = 0; c < N; c++)
      arr.rd_data[c] = data[arr.rd_row][c];
  end

  // Readout is handled by the controller, never as an array operation
  a_no_read_op : assert property (@(posedge clk) disable iff (!rstnn)
    arr.op_valid |-> (arr.op != OP_READ))
    else $error("matrix_array: read opcode issued as an array operation");

endmodule

// File: rtl/matrix_ctrl_fsm.sv
`include "matrix_defines.svh"

module matrix_ctrl_fsm
(
  input  logic              clk,
  input  logic              rstnn,
  input  logic              i_empty,
  input  matrix_pkg::cmd_t  i_cmd,
  output logic              o_pop,
  input  logic              i_has_credit,
  output logic              o_row_valid,
  output matrix_pkg::idx_t  o_row_index,
  output matrix_pkg::row_t  o_row_data,
  matrix_array_if.ctrl      arr
);
  import matrix_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    READOUT
  } state_e;

  localparam idx_t LAST_ROW = idx_t'(`MATRIX_N - 1);

  state_e state;
  cmd_t   cmd_q;
  idx_t   row_idx;
  logic   row_issue;

  assign o_pop     = (state == IDLE) && !i_empty;
  assign row_issue = (state == READOUT) && i_has_credit;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      state   <= IDLE;
      row_idx <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (o_pop)
          begin
            if (i_cmd.op == OP_READ)
            begin
              state   <= READOUT;
              row_idx <= '0;
            end
            else
              state <= EXEC;
          end
        end
        EXEC:
          state <= IDLE;
        READOUT:
        begin
          if (row_issue)
          begin
            if (row_idx == LAST_ROW)
              state <= IDLE;
            else
              row_idx <= row_idx + 1'b1;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (o_pop)
      cmd_q <= i_cmd;
  end

  // Array operation is held for the single EXEC cycle
  assign arr.op_valid = (state == EXEC);
  assign arr.op       = cmd_q.op;
  assign arr.row      = cmd_q.row;
  assign arr.col      = cmd_q.col;
  assign arr.wdata    = cmd_q.data;
  assign arr.rd_row   = row_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Row output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      o_row_valid <= 1'b0;
      o_row_index <= '0;
    end
    else
    begin
      o_row_valid <= row_issue;
      if (row_issue)
        o_row_index <= row_idx;
    end
  end

  always_ff @(posedge clk)
  begin
    if (row_issue)
      o_row_data <= arr.rd_data;
  end

endmodule

// File: rtl/credit_counter.sv
`include "matrix_defines.svh"

module credit_counter
(
  input  logic clk,
  input  logic rstnn,
  input  logic i_grant,
  input  logic i_spend,
  output logic o_has_credit
);

  localparam int MAX_CREDIT = `ROW_CREDIT_MAX;
  localparam int CNT_W      = $clog2(MAX_CREDIT + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      count <= '0;
    end
    else
    begin
      case ({i_grant, i_spend})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A row leaving this cycle already owns one of the counted credits
  assign o_has_credit = (count > CNT_W'(1)) || ((count == CNT_W'(1)) && !i_spend);

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  a_no_overflow : assert property (@(posedge clk) disable iff (!rstnn)
    (i_grant && !i_spend) |-> (count < CNT_W'(MAX_CREDIT)))
    else $error("credit_counter: receiver granted too many row credits");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rstnn)
    i_spend |-> (count != '0))
    else $error("credit_counter: row sent without a credit");

endmodule

// File: rtl/cmd_queue.sv
`include "matrix_defines.svh"

module cmd_queue
(
  input  logic              clk,
  input  logic              rstnn,
  input  logic              i_push,
  input  matrix_pkg::cmd_t  i_cmd,
  input  logic              i_pop,
  output logic              o_empty,
  output matrix_pkg::cmd_t  o_cmd,
  output logic              o_credit
);
  import matrix_pkg::*;

  localparam int DEPTH = `CMD_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  cmd_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_pop;

  assign o_empty = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_pop  = i_pop && !o_empty;
  assign o_cmd   = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (i_push)
    begin
      mem[wr_ptr] <= i_cmd;
    end
  end

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end
    else
    begin
      if (i_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (i_push && !do_pop)
        count <= count + 1'b1;
      else if (!i_push && do_pop)
        count <= count - 1'b1;
      // Each released entry hands one credit back to the sender
      o_credit <= do_pop;
    end
  end

  // Sender must stay within its credits
  a_no_overflow : assert property (@(posedge clk) disable iff (!rstnn)
    !(i_push && full))
    else $error("cmd_queue: command pushed while full");

endmodule

// File: rtl/matrix_array_if.sv
interface matrix_array_if;
  import matrix_pkg::*;

  // Operation request, one cycle per command
  logic       op_valid;
  matrix_op_e op;
  idx_t       row;
  idx_t       col;
  scalar_t    wdata;

  // Row read port, combinational
  idx_t       rd_row;
  row_t       rd_data;

  modport ctrl (
    output op_valid, op, row, col, wdata, rd_row,
    input  rd_data
  );

  modport array (
    input  op_valid, op, row, col, wdata, rd_row,
    output rd_data
  );

endinterface

// File: rtl/matrix_pkg.sv
`include "matrix_defines.svh"

package matrix_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`SCALAR_W-1:0] scalar_t;

  // Column 0 sits in the lowest bits
  typedef scalar_t [`MATRIX_N-1:0] row_t;

  typedef logic [$clog2(`MATRIX_N)-1:0] idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_INIT        = 3'd0,
    OP_WRITE       = 3'd1,
    OP_SHIFT_UP    = 3'd2,
    OP_SHIFT_DOWN  = 3'd3,
    OP_SHIFT_LEFT  = 3'd4,
    OP_SHIFT_RIGHT = 3'd5,
    OP_TRANSPOSE   = 3'd6,
    OP_READ        = 3'd7
  } matrix_op_e;

  // Row, col and data only matter for OP_WRITE
  typedef struct packed {
    matrix_op_e op;
    idx_t       row;
    idx_t       col;
    scalar_t    data;
  } cmd_t;

endpackage

// File: rtl/matrix_defines.svh
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Matrix geometry
////////////////////////////////////////////////////////////////////////////

// Rows and columns of the square matrix
`define MATRIX_N 4
`define SCALAR_W 16

////////////////////////////////////////////////////////////////////////////
// Flow control
////////////////////////////////////////////////////////////////////////////

// Also the number of command credits the sender starts with
`define CMD_DEPTH 4
`define ROW_CREDIT_MAX 4

// Written to every element by the init command
`define MATRIX_INIT_VALUE 16'h0001

`endif
